// File: verilog.f
+incdir+design
design/pcie_reg_pkg.sv
design/pcie_dma_pkg.sv
design/pio_reg_file.sv
design/rb_pointer_select.sv
design/dma_desc_builder.sv
design/pcie_f2c_top.sv
sim/pcie_f2c_assert.sv
sim/pcie_f2c_checker.sv
sim/tb_pcie_f2c.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run tb_pcie_f2c and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_pcie_f2c -Mdir obj_dir -f verilog.f
	./obj_dir/Vtb_pcie_f2c | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: sim/tb_pcie_f2c.sv
`timescale 1ns/1ps
`include "pcie_defs.svh"

module tb_pcie_f2c;

    localparam int N_UPDATES       = 24;
    localparam int RB_SLOTS        = 32;
    localparam int N_CORES_USED    = 3;
    localparam int PIO_CYCLES      = 1000;
    localparam int WATCHDOG_CYCLES = (N_UPDATES + 2) * 200 + PIO_CYCLES;

    logic                          pcie_clk;
    logic                          pcie_reset_n;
    pcie_reg_pkg::pio_write_t      pio_wr;
    logic [`PCIE_PIO_AWIDTH-1:0]   rd_address;
    logic                          rd;
    logic [`PCIE_PIO_DWIDTH-1:0]   readdata;
    logic                          readdatavalid;
    logic                          upd_req;
    pcie_dma_pkg::rb_update_t      upd_data;
    logic                          upd_ack;
    logic                          desc_req;
    pcie_dma_pkg::dma_desc_t       desc_data;
    logic                          desc_ack;

    // expectations for the checker
    pcie_dma_pkg::dma_desc_t       exp_desc;
    logic [`PCIE_PIO_DWIDTH-1:0]   exp_rdata;
    logic                          desc_allowed;
    int                            err_count;
    int                            check_count;
    int                            desc_count;
    int                            tb_errors;

    // shadow of the register pages, dword 0 of sh_regs unused
    logic [31:0]                   sh_regs [`PCIE_NB_CORES][`PCIE_REGS_PER_PAGE];
    logic [15:0]                   sh_tail [`PCIE_NB_CORES];
    logic [31:0]                   sh_ctrl;
    int                            exp_core;
    logic [15:0]                   pend_tail;

    pcie_f2c_top u_dut (.*);

    pcie_f2c_checker u_chk (.*);

    initial begin
        pcie_clk = 1'b0;
        forever #2 pcie_clk = ~pcie_clk;
    end

    // expected descriptor and next tail of one update
    function automatic pcie_dma_pkg::dma_desc_t ref_update(
        input logic [63:0] kmem,
        input logic [15:0] tail,
        input logic [15:0] size,
        input int          core,
        input int          rb_slots,
        output logic [15:0] next_tail
    );
        pcie_dma_pkg::dma_desc_t d;
        d.dest_addr    = kmem + 64'(tail) * 64'd64;
        d.length_bytes = 24'(size) * 24'd64;
        d.core_id      = 4'(core);
        next_tail      = 16'((int'(tail) + int'(size)) % rb_slots);
        return d;
    endfunction

    // ring size less used slots less the guard slot
    function automatic int ref_free(input int head, input int tail, input int rb_slots);
        int used;
        used = (tail >= head) ? tail - head : tail + rb_slots - head;
        return rb_slots - used - 1;
    endfunction

    function automatic logic [127:0] page_word(input int page);
        if (page < `PCIE_NB_CORES) begin
            return {sh_regs[page][3], sh_regs[page][2], sh_regs[page][1], 16'h0, sh_tail[page]};
        end
        return {96'h0, sh_ctrl};
    endfunction

    function automatic logic [127:0] random128();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic pio_write(input int page, input logic [127:0] data, input logic [15:0] be);
        pio_wr.address    = 8'(page << `PCIE_PAGE_LSB);
        pio_wr.writedata  = data;
        pio_wr.byteenable = be;
        pio_wr.write      = 1'b1;
        // only whole dwords land, tails never from the CPU
        for (int i = 0; i < `PCIE_REGS_PER_PAGE; i++) begin
            if (be[i*4 +: 4] == 4'hf) begin
                if (page < `PCIE_NB_CORES && i != 0) begin
                    sh_regs[page][i] = data[i*32 +: 32];
                end else if (page == `PCIE_CTRL_PAGE && i == 0) begin
                    sh_ctrl = data[31:0];
                end
            end
        end
        @(negedge pcie_clk);
        pio_wr.write = 1'b0;
    endtask

    task automatic set_head(input int core, input logic [15:0] head);
        pio_write(core, {64'h0, 16'h0, head, 32'h0}, 16'h00f0);
    endtask

    task automatic pio_read_check(input int page);
        int waited;
        rd_address = 8'(page << `PCIE_PAGE_LSB);
        rd         = 1'b1;
        exp_rdata  = page_word(page);
        @(negedge pcie_clk);
        rd     = 1'b0;
        waited = 0;
        do begin
            @(posedge pcie_clk);
            waited++;
        end while (!readdatavalid && waited < 10);
        if (!readdatavalid) begin
            $display("no read data came back for page %0d", page);
            tb_errors++;
        end
        @(negedge pcie_clk);
    endtask

    task automatic start_update(input logic [15:0] size);
        exp_desc = ref_update({sh_regs[exp_core][3], sh_regs[exp_core][2]},
                              sh_tail[exp_core], size, exp_core, RB_SLOTS, pend_tail);
        upd_data.size = size;
        upd_req       = 1'b1;
    endtask

    task automatic finish_update();
        int waited;
        waited = 0;
        while (!upd_ack && waited < 200) begin
            @(posedge pcie_clk);
            waited++;
        end
        if (!upd_ack) begin
            $display("update for core %0d was never acknowledged", exp_core);
            tb_errors++;
        end
        @(negedge pcie_clk);
        upd_req = 1'b0;
        while (upd_ack) begin
            @(posedge pcie_clk);
        end
        @(negedge pcie_clk);
        sh_tail[exp_core] = pend_tail;
        exp_core = (exp_core + 1) % N_CORES_USED;
    endtask

    task automatic publish(input logic [15:0] size);
        // CPU drains the ring when the batch would not fit
        if (ref_free(int'(sh_regs[exp_core][1][15:0]), int'(sh_tail[exp_core]), RB_SLOTS)
            < int'(size)) begin
            set_head(exp_core, sh_tail[exp_core]);
        end
        start_update(size);
        finish_update();
    endtask

    // DMA engine, acks after 0 to 5 cycles
    initial begin
        int delay;
        desc_ack = 1'b0;
        forever begin
            @(posedge pcie_clk);
            if (desc_req && !desc_ack) begin
                delay = $urandom_range(0, 5);
                repeat (delay) @(posedge pcie_clk);
                @(negedge pcie_clk);
                desc_ack = 1'b1;
                while (desc_req) begin
                    @(posedge pcie_clk);
                end
                @(negedge pcie_clk);
                desc_ack = 1'b0;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge pcie_clk);
        $display("timeout, the test sequence did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        pcie_reg_pkg::ctrl_reg_t cfg;
        void'($urandom(95605));
        pcie_reset_n = 1'b0;
        pio_wr       = '0;
        rd_address   = '0;
        rd           = 1'b0;
        upd_req      = 1'b0;
        upd_data     = '0;
        exp_desc     = '0;
        exp_rdata    = '0;
        desc_allowed = 1'b0;
        tb_errors    = 0;
        exp_core     = 0;
        pend_tail    = '0;
        sh_ctrl      = '0;
        for (int c = 0; c < `PCIE_NB_CORES; c++) begin
            sh_tail[c] = '0;
            for (int i = 0; i < `PCIE_REGS_PER_PAGE; i++) begin
                sh_regs[c][i] = '0;
            end
        end
        repeat (8) @(posedge pcie_clk);
        @(negedge pcie_clk);
        pcie_reset_n = 1'b1;

        // register access with full and random byte enables
        for (int p = 0; p < `PCIE_NB_CORES; p++) begin
            pio_write(p, random128(), 16'hffff);
            pio_read_check(p);
        end
        for (int n = 0; n < 12; n++) begin
            pio_write(n % 4, random128(), 16'($urandom));
            pio_read_check(n % 4);
        end
        pio_write(`PCIE_CTRL_PAGE, random128(), 16'h0007);
        pio_read_check(`PCIE_CTRL_PAGE);
        pio_write(`PCIE_CTRL_PAGE, random128(), 16'hfff0);
        pio_read_check(`PCIE_CTRL_PAGE);

        // rings empty, then enable
        for (int p = 0; p < `PCIE_NB_CORES; p++) begin
            set_head(p, 16'h0);
        end
        cfg            = '0;
        cfg.enable     = 1'b1;
        cfg.rb_size    = 26'(RB_SLOTS);
        cfg.total_core = 5'(N_CORES_USED);
        pio_write(`PCIE_CTRL_PAGE, {96'h0, 32'(cfg)}, 16'h000f);
        desc_allowed = 1'b1;
        for (int n = 0; n < N_UPDATES; n++) begin
            publish(16'($urandom_range(1, 12)));
        end
        for (int p = 0; p <= `PCIE_CTRL_PAGE; p++) begin
            pio_read_check(p);
        end

        // full ring holds the update until the head moves on
        set_head(exp_core, 16'((int'(sh_tail[exp_core]) + 1) % RB_SLOTS));
        desc_allowed = 1'b0;
        start_update(16'd4);
        repeat (50) @(negedge pcie_clk);
        desc_allowed = 1'b1;
        set_head(exp_core, 16'((int'(sh_tail[exp_core]) + 17) % RB_SLOTS));
        finish_update();

        // disabled design holds it until enable returns
        cfg.enable = 1'b0;
        pio_write(`PCIE_CTRL_PAGE, {96'h0, 32'(cfg)}, 16'h000f);
        set_head(exp_core, sh_tail[exp_core]);
        desc_allowed = 1'b0;
        start_update(16'd6);
        repeat (50) @(negedge pcie_clk);
        desc_allowed = 1'b1;
        cfg.enable   = 1'b1;
        pio_write(`PCIE_CTRL_PAGE, {96'h0, 32'(cfg)}, 16'h000f);
        finish_update();
        for (int p = 0; p <= `PCIE_CTRL_PAGE; p++) begin
            pio_read_check(p);
        end

        if (desc_count != N_UPDATES + 2) begin
            $display("expected %0d descriptors but the DMA port saw %0d",
                     N_UPDATES + 2, desc_count);
            tb_errors++;
        end
        $display("checks: %0d, checker errors: %0d, sequence errors: %0d",
                 check_count, err_count, tb_errors);
        if (err_count + tb_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: sim/pcie_f2c_checker.sv
`timescale 1ns/1ps
`include "pcie_defs.svh"

module pcie_f2c_checker (
    input  logic                          pcie_clk,
    input  logic                          pcie_reset_n,
    input  logic                          desc_req,
    input  pcie_dma_pkg::dma_desc_t       desc_data,
    input  logic [`PCIE_PIO_DWIDTH-1:0]   readdata,
    input  logic                          readdatavalid,
    input  logic                          rd,
    input  pcie_dma_pkg::dma_desc_t       exp_desc,
    input  logic [`PCIE_PIO_DWIDTH-1:0]   exp_rdata,
    input  logic                          desc_allowed,
    output int                            err_count,
    output int                            check_count,
    output int                            desc_count
);

    logic desc_req_q;
    logic rd_q1;
    logic rd_q2;

    // DUT outputs are registered, so the posedge sample is last cycle's value
    initial begin
        err_count   = 0;
        check_count = 0;
        desc_count  = 0;
        desc_req_q  = 1'b0;
        rd_q1       = 1'b0;
        rd_q2       = 1'b0;
        forever begin
            @(posedge pcie_clk);
            if (pcie_reset_n) begin
                // new descriptor on the rising desc_req
                if (desc_req && !desc_req_q) begin
                    check_count++;
                    desc_count++;
                    if (!desc_allowed) begin
                        err_count++;
                        $display("%0t: descriptor for core %0d issued while the ring %s",
                                 $time, desc_data.core_id,
                                 "was full or the design was disabled");
                    end else if (desc_data !== exp_desc) begin
                        err_count++;
                        $display("ERR %0t: descriptor dest %h len %0d core %0d",
                                 $time, desc_data.dest_addr, desc_data.length_bytes,
                                 desc_data.core_id);
                        $display("ERR %0t: expected dest %h len %0d core %0d",
                                 $time, exp_desc.dest_addr, exp_desc.length_bytes,
                                 exp_desc.core_id);
                    end
                end
                // read data is due two cycles after the request
                if (readdatavalid !== rd_q2) begin
                    err_count++;
                    $display("ERR %0t: readdatavalid %b, expected %b two cycles after rd",
                             $time, readdatavalid, rd_q2);
                end
                if (readdatavalid) begin
                    check_count++;
                    if (readdata !== exp_rdata) begin
                        err_count++;
                        $display("ERR %0t: readback %h, expected %h",
                                 $time, readdata, exp_rdata);
                    end
                end
            end
            desc_req_q = desc_req;
            rd_q2      = rd_q1;
            rd_q1      = rd;
        end
    end

endmodule

// File: sim/pcie_f2c_assert.sv
`timescale 1ns/1ps

module pcie_f2c_assert (
    input logic                    pcie_clk,
    input logic                    pcie_reset_n,
    input logic                    upd_req,
    input logic                    upd_ack,
    input logic                    desc_req,
    input logic                    desc_ack,
    input pcie_dma_pkg::dma_desc_t desc_data,
    input logic                    readdatavalid,
    input logic                    tail_done
);

    // descriptor held while offered to the engine
    a_desc_stable: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        desc_req && $past(desc_req) |-> $stable(desc_data))
        else $error("desc_data changed while desc_req was high");

    // ack only answers a live request
    a_ack_with_req: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        $rose(upd_ack) |-> upd_req)
        else $error("upd_ack rose without upd_req");

    a_ack_release: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        !upd_req && !desc_ack |=> !upd_ack)
        else $error("upd_ack stayed high with no upd_req");

    // upstream ack and tail pulse one cycle after the engine ack
    a_ack_after_desc: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        desc_req && desc_ack |=> upd_ack && tail_done && !desc_req)
        else $error("upd_ack or tail_done did not follow desc_ack by one cycle");

    a_reset_quiet: assert property (@(posedge pcie_clk)
        !pcie_reset_n |=> !upd_ack && !desc_req && !readdatavalid && !tail_done)
        else $error("control outputs not low after reset");

endmodule

bind pcie_f2c_top pcie_f2c_assert u_assert (
    .pcie_clk      (pcie_clk),
    .pcie_reset_n  (pcie_reset_n),
    .upd_req       (upd_req),
    .upd_ack       (upd_ack),
    .desc_req      (desc_req),
    .desc_ack      (desc_ack),
    .desc_data     (desc_data),
    .readdatavalid (readdatavalid),
    .tail_done     (tail_done)
);

// File: design/pcie_f2c_top.sv
`timescale 1ns/1ps
`include "pcie_defs.svh"

module pcie_f2c_top (
    input  logic                           pcie_clk,
    input  logic                           pcie_reset_n,

    // PIO port from the CPU
    input  pcie_reg_pkg::pio_write_t       pio_wr,
    input  logic [`PCIE_PIO_AWIDTH-1:0]    rd_address,
    input  logic                           rd,
    output logic [`PCIE_PIO_DWIDTH-1:0]    readdata,
    output logic                           readdatavalid,

    // upstream update request
    input  logic                           upd_req,
    input  pcie_dma_pkg::rb_update_t       upd_data,
    output logic                           upd_ack,

    // DMA write descriptor port
    output logic                           desc_req,
    output pcie_dma_pkg::dma_desc_t        desc_data,
    input  logic                           desc_ack
);

    pcie_reg_pkg::ctrl_reg_t       ctrl;
    pcie_reg_pkg::core_heads_t     heads;
    pcie_reg_pkg::core_kmem_t      kmem_addrs;
    pcie_reg_pkg::tail_update_t    tail_upd;
    pcie_reg_pkg::ring_ctx_t       ctx;
    logic [`PCIE_CORE_IDW-1:0]     core_id;
    logic                          tail_done;
    logic [`PCIE_RB_AWIDTH-1:0]    new_tail;

    pio_reg_file u_pio_reg_file (
        .pcie_clk      (pcie_clk),
        .pcie_reset_n  (pcie_reset_n),
        .pio_wr        (pio_wr),
        .rd_address    (rd_address),
        .rd            (rd),
        .readdata      (readdata),
        .readdatavalid (readdatavalid),
        .tail_upd      (tail_upd),
        .ctrl          (ctrl),
        .heads         (heads),
        .kmem_addrs    (kmem_addrs)
    );

    rb_pointer_select u_rb_pointer_select (
        .pcie_clk      (pcie_clk),
        .pcie_reset_n  (pcie_reset_n),
        .ctrl          (ctrl),
        .heads         (heads),
        .kmem_addrs    (kmem_addrs),
        .tail_done     (tail_done),
        .new_tail      (new_tail),
        .ctx           (ctx),
        .core_id       (core_id),
        .tail_upd      (tail_upd)
    );

    dma_desc_builder u_dma_desc_builder (
        .pcie_clk      (pcie_clk),
        .pcie_reset_n  (pcie_reset_n),
        .ctrl          (ctrl),
        .ctx           (ctx),
        .core_id       (core_id),
        .upd_req       (upd_req),
        .upd_data      (upd_data),
        .upd_ack       (upd_ack),
        .desc_req      (desc_req),
        .desc_data     (desc_data),
        .desc_ack      (desc_ack),
        .tail_done     (tail_done),
        .new_tail      (new_tail)
    );

endmodule

// File: design/dma_desc_builder.sv
`timescale 1ns/1ps
`include "pcie_defs.svh"

module dma_desc_builder (
    input  logic                          pcie_clk,
    input  logic                          pcie_reset_n,
    input  pcie_reg_pkg::ctrl_reg_t       ctrl,
    input  pcie_reg_pkg::ring_ctx_t       ctx,
    input  logic [`PCIE_CORE_IDW-1:0]     core_id,
    input  logic                          upd_req,
    input  pcie_dma_pkg::rb_update_t      upd_data,
    output logic                          upd_ack,
    output logic                          desc_req,
    output pcie_dma_pkg::dma_desc_t       desc_data,
    input  logic                          desc_ack,
    output logic                          tail_done,
    output logic [`PCIE_RB_AWIDTH-1:0]    new_tail
);

    // one bit wider than rb_size so sums do not overflow
    localparam int SW = 27;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CHECK,
        S_ISSUE,
        S_RELEASE
    } state_t;

    state_t                      state;
    logic [`PCIE_RB_AWIDTH-1:0]  size_q;
    logic [SW-1:0]               ring_slots;
    logic [SW-1:0]               head_w;
    logic [SW-1:0]               tail_w;
    logic [SW-1:0]               used_slots;
    logic [SW-1:0]               tail_sum;
    logic                        space_ok;
    logic                        go;

    assign ring_slots = SW'(ctrl.rb_size);
    assign head_w     = SW'(ctx.head);
    assign tail_w     = SW'(ctx.tail);
    assign tail_sum   = tail_w + SW'(size_q);

    // occupancy from head to tail, then free space minus the guard slot
    always_comb begin
        if (tail_w >= head_w) begin
            used_slots = tail_w - head_w;
        end else begin
            used_slots = tail_w + ring_slots - head_w;
        end
        space_ok = (ring_slots != '0) && (used_slots < ring_slots) &&
                   (ring_slots - used_slots - 1'b1 >= SW'(size_q));
    end

    assign go = (state == S_CHECK) && ctrl.enable && space_ok;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            state     <= S_IDLE;
            upd_ack   <= 1'b0;
            desc_req  <= 1'b0;
            tail_done <= 1'b0;
        end else begin
            tail_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (upd_req) begin
                        state <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    // hold here while disabled or ring full
                    if (go) begin
                        desc_req <= 1'b1;
                        state    <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (desc_ack) begin
                        desc_req  <= 1'b0;
                        tail_done <= 1'b1;
                        upd_ack   <= 1'b1;
                        state     <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    // both partners must have let go
                    if (!upd_req && !desc_ack) begin
                        upd_ack <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // payload, held stable from ISSUE until the next request
    always_ff @(posedge pcie_clk) begin
        if (state == S_IDLE && upd_req) begin
            size_q <= upd_data.size;
        end
        if (go) begin
            desc_data.dest_addr    <= ctx.kmem_addr +
                                      (64'(ctx.tail) << `PCIE_SLOT_BYTES_LOG2);
            desc_data.length_bytes <= `PCIE_DESC_LEN_W'(size_q) << `PCIE_SLOT_BYTES_LOG2;
            desc_data.core_id      <= core_id;
            // wrap the tail at the ring size
            if (tail_sum >= ring_slots) begin
                new_tail <= `PCIE_RB_AWIDTH'(tail_sum - ring_slots);
            end else begin
                new_tail <= `PCIE_RB_AWIDTH'(tail_sum);
            end
        end
    end

endmodule

// File: design/rb_pointer_select.sv
`timescale 1ns/1ps
`include "pcie_defs.svh"

module rb_pointer_select (
    input  logic                            pcie_clk,
    input  logic                            pcie_reset_n,
    input  pcie_reg_pkg::ctrl_reg_t         ctrl,
    input  pcie_reg_pkg::core_heads_t       heads,
    input  pcie_reg_pkg::core_kmem_t        kmem_addrs,
    input  logic                            tail_done,
    input  logic [`PCIE_RB_AWIDTH-1:0]      new_tail,
    output pcie_reg_pkg::ring_ctx_t         ctx,
    output logic [`PCIE_CORE_IDW-1:0]       core_id,
    output pcie_reg_pkg::tail_update_t      tail_upd
);

    localparam int SEL_W = $clog2(`PCIE_NB_CORES);

    // local copy of every tail
    logic [`PCIE_RB_AWIDTH-1:0] tails [`PCIE_NB_CORES];
    logic [4:0]                 active_cores;
    logic [4:0]                 core_inc;
    logic [SEL_W-1:0]           core_sel;

    assign core_sel = core_id[SEL_W-1:0];
    assign core_inc = 5'(core_id) + 5'd1;

    // zero counts as one core, and never more than there are pages
    always_comb begin
        if (ctrl.total_core == 5'd0) begin
            active_cores = 5'd1;
        end else if (ctrl.total_core > 5'(`PCIE_NB_CORES)) begin
            active_cores = 5'(`PCIE_NB_CORES);
        end else begin
            active_cores = ctrl.total_core;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            for (int c = 0; c < `PCIE_NB_CORES; c++) begin
                tails[c] <= '0;
            end
            core_id <= '0;
            ctx     <= '0;
        end else begin
            if (tail_done) begin
                tails[core_sel] <= new_tail;
                // round robin over the active cores
                if (core_inc >= active_cores) begin
                    core_id <= '0;
                end else begin
                    core_id <= core_id + 1'b1;
                end
            end
            ctx.head      <= heads[core_sel];
            ctx.tail      <= tails[core_sel];
            ctx.kmem_addr <= kmem_addrs[core_sel];
        end
    end

    // tail goes back to the register page in the same cycle
    always_comb begin
        tail_upd.valid    = tail_done;
        tail_upd.core_id  = core_id;
        tail_upd.new_tail = new_tail;
    end

endmodule

// File: design/pio_reg_file.sv
`timescale 1ns/1ps
`include "pcie_defs.svh"

module pio_reg_file (
    input  logic                              pcie_clk,
    input  logic                              pcie_reset_n,
    input  pcie_reg_pkg::pio_write_t          pio_wr,
    input  logic [`PCIE_PIO_AWIDTH-1:0]       rd_address,
    input  logic                              rd,
    output logic [`PCIE_PIO_DWIDTH-1:0]       readdata,
    output logic                              readdatavalid,
    input  pcie_reg_pkg::tail_update_t        tail_upd,
    output pcie_reg_pkg::ctrl_reg_t           ctrl,
    output pcie_reg_pkg::core_heads_t         heads,
    output pcie_reg_pkg::core_kmem_t          kmem_addrs
);

    localparam int SEL_W  = $clog2(`PCIE_NB_CORES);
    localparam int PAGE_W = `PCIE_PIO_AWIDTH - `PCIE_PAGE_LSB;

    // dwords 1..3 of every core page, the tail lives apart
    logic [31:0]                  page_regs [`PCIE_NB_CORES][1:`PCIE_REGS_PER_PAGE-1];
    logic [`PCIE_RB_AWIDTH-1:0]   tails [`PCIE_NB_CORES];
    pcie_reg_pkg::ctrl_reg_t      ctrl_q;

    logic [PAGE_W-1:0]            wr_page;
    logic [PAGE_W-1:0]            rd_page;
    logic [`PCIE_PIO_DWIDTH-1:0]  rd_word;
    logic [`PCIE_PIO_DWIDTH-1:0]  rd_word_q;
    logic                         rd_q;

    assign wr_page = pio_wr.address[`PCIE_PIO_AWIDTH-1:`PCIE_PAGE_LSB];
    assign rd_page = rd_address[`PCIE_PIO_AWIDTH-1:`PCIE_PAGE_LSB];

    // CPU writes and hardware tail writes
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            for (int c = 0; c < `PCIE_NB_CORES; c++) begin
                tails[c] <= '0;
                for (int i = 1; i < `PCIE_REGS_PER_PAGE; i++) begin
                    page_regs[c][i] <= '0;
                end
            end
            ctrl_q <= '0;
        end else begin
            if (pio_wr.write) begin
                if (wr_page < PAGE_W'(`PCIE_NB_CORES)) begin
                    // dword 0 is the tail, skipped on purpose
                    for (int i = 1; i < `PCIE_REGS_PER_PAGE; i++) begin
                        if (pio_wr.byteenable[i*4 +: 4] == 4'hf) begin
                            page_regs[wr_page[SEL_W-1:0]][i] <= pio_wr.writedata[i*32 +: 32];
                        end
                    end
                end else if (wr_page == PAGE_W'(`PCIE_CTRL_PAGE)) begin
                    if (pio_wr.byteenable[`PCIE_REG_CTRL*4 +: 4] == 4'hf) begin
                        ctrl_q <= pcie_reg_pkg::ctrl_reg_t'(
                            pio_wr.writedata[`PCIE_REG_CTRL*32 +: 32]);
                    end
                end
            end
            if (tail_upd.valid) begin
                tails[tail_upd.core_id[SEL_W-1:0]] <= tail_upd.new_tail;
            end
        end
    end

    // page mux for readback, unused dwords read as zero
    always_comb begin
        rd_word = '0;
        if (rd_page < PAGE_W'(`PCIE_NB_CORES)) begin
            rd_word[`PCIE_REG_TAIL*32 +: 32] = 32'(tails[rd_page[SEL_W-1:0]]);
            for (int i = 1; i < `PCIE_REGS_PER_PAGE; i++) begin
                rd_word[i*32 +: 32] = page_regs[rd_page[SEL_W-1:0]][i];
            end
        end else if (rd_page == PAGE_W'(`PCIE_CTRL_PAGE)) begin
            rd_word[`PCIE_REG_CTRL*32 +: 32] = ctrl_q;
        end
    end

    // two-stage read pipeline
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            rd_q          <= 1'b0;
            readdatavalid <= 1'b0;
        end else begin
            rd_q          <= rd;
            readdatavalid <= rd_q;
        end
    end

    always_ff @(posedge pcie_clk) begin
        rd_word_q <= rd_word;
        readdata  <= rd_word_q;
    end

    // views for the pointer stage
    always_comb begin
        for (int c = 0; c < `PCIE_NB_CORES; c++) begin
            heads[c]      = page_regs[c][`PCIE_REG_HEAD][`PCIE_RB_AWIDTH-1:0];
            kmem_addrs[c] = {page_regs[c][`PCIE_REG_KMEM_HI],
                             page_regs[c][`PCIE_REG_KMEM_LO]};
        end
    end

    assign ctrl = ctrl_q;

endmodule

// File: design/pcie_dma_pkg.sv
`include "pcie_defs.svh"

package pcie_dma_pkg;

    // publish request from the upstream data source
    typedef struct packed {
        logic [`PCIE_RB_AWIDTH-1:0] size;
    } rb_update_t;

    // write descriptor for the DMA engine
    // dest_addr is the kernel buffer byte address of the first slot
    typedef struct packed {
        logic [63:0]                 dest_addr;
        logic [`PCIE_DESC_LEN_W-1:0] length_bytes;
        logic [`PCIE_CORE_IDW-1:0]   core_id;
    } dma_desc_t;

endpackage

// File: design/pcie_reg_pkg.sv
`include "pcie_defs.svh"

package pcie_reg_pkg;

    // global control word, enable sits in bit 0
    typedef struct packed {
        logic [4:0]  total_core;
        logic [25:0] rb_size;
        logic        enable;
    } ctrl_reg_t;

    // CPU write bundle
    typedef struct packed {
        logic [`PCIE_PIO_AWIDTH-1:0]  address;
        logic [`PCIE_PIO_DWIDTH-1:0]  writedata;
        logic [`PCIE_PIO_BEWIDTH-1:0] byteenable;
        logic                         write;
    } pio_write_t;

    // ring context of the core being served
    typedef struct packed {
        logic [`PCIE_RB_AWIDTH-1:0] head;
        logic [`PCIE_RB_AWIDTH-1:0] tail;
        logic [63:0]                kmem_addr;
    } ring_ctx_t;

    // hardware tail write into the register pages
    typedef struct packed {
        logic                       valid;
        logic [`PCIE_CORE_IDW-1:0]  core_id;
        logic [`PCIE_RB_AWIDTH-1:0] new_tail;
    } tail_update_t;

    // per-core views handed to the pointer stage
    typedef logic [`PCIE_NB_CORES-1:0][`PCIE_RB_AWIDTH-1:0] core_heads_t;
    typedef logic [`PCIE_NB_CORES-1:0][63:0]                core_kmem_t;

endpackage

// File: design/pcie_defs.svh
`ifndef PCIE_DEFS_SVH
`define PCIE_DEFS_SVH

// core pages and ring pointers
`define PCIE_NB_CORES         4
`define PCIE_CORE_IDW         4
`define PCIE_RB_AWIDTH        16

// PIO port geometry, byte addressed with 128-bit data
`define PCIE_PIO_AWIDTH       8
`define PCIE_PIO_DWIDTH       128
`define PCIE_PIO_BEWIDTH      16

// one page holds four dwords, so the page index starts at bit 4
`define PCIE_REGS_PER_PAGE    4
`define PCIE_PAGE_LSB         4
`define PCIE_CTRL_PAGE        4

// dword offsets inside a core page
`define PCIE_REG_TAIL         0
`define PCIE_REG_HEAD         1
`define PCIE_REG_KMEM_LO      2
`define PCIE_REG_KMEM_HI      3
// dword offset inside the control page
`define PCIE_REG_CTRL         0

// slots are 64 bytes
`define PCIE_SLOT_BYTES_LOG2  6
`define PCIE_DESC_LEN_W       24

`endif
